/* source/lsb_defines.svh */
`ifndef LSB_DEFINES_SVH
`define LSB_DEFINES_SVH

// queue geometry
`define LSB_DEPTH 16
`define LSB_IDX_W 4

// reorder tags, zero is reserved for "no tag"
`define ROB_ID_W 4

// data and address width
`define XLEN 32

// cache geometry
`define LINE_BYTES 16
`define LINE_W (`LINE_BYTES * 8)
`define CACHE_LINES 16

// address split: tag | index | offset
`define OFFSET_W 4
`define INDEX_W 4
`define TAG_W (`XLEN - `INDEX_W - `OFFSET_W)

`endif

/* source/lsb_pkg.sv */
`include "lsb_defines.svh"

package lsb_pkg;

  typedef logic [`ROB_ID_W-1:0]  rob_id_t;
  typedef logic [`XLEN-1:0]      word_t;
  typedef logic [`XLEN-1:0]      addr_t;
  typedef logic [`LINE_W-1:0]    line_t;
  typedef logic [`LSB_IDX_W-1:0] lsb_idx_t;

  // loads first, stores after
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsb_op_e;

  // miss handling toward memory
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    REFILL    = 2'd1,
    WRITEBACK = 2'd2
  } cache_state_e;

endpackage

/* source/ls_queue.sv */
`timescale 1ns/1ps
`include "lsb_defines.svh"

module ls_queue (
  input  logic              clk,
  input  logic              reset_from_rob_bus,
  input  logic              issue_valid,
  input  lsb_pkg::lsb_op_e  issue_op,
  input  lsb_pkg::rob_id_t  issue_dest,
  input  lsb_pkg::rob_id_t  issue_qj,
  input  lsb_pkg::rob_id_t  issue_qk,
  input  lsb_pkg::word_t    issue_vj,
  input  lsb_pkg::word_t    issue_vk,
  input  lsb_pkg::word_t    issue_imm,
  input  logic              cdb_valid,
  input  lsb_pkg::rob_id_t  cdb_dest,
  input  lsb_pkg::word_t    cdb_value,
  input  logic              result_valid,
  input  lsb_pkg::rob_id_t  result_dest,
  input  lsb_pkg::word_t    result_value,
  input  logic              commit_valid,
  input  lsb_pkg::rob_id_t  commit_dest,
  input  logic              head_done,
  output logic              issue_ready,
  output logic              head_valid,
  output lsb_pkg::lsb_op_e  head_op,
  output lsb_pkg::addr_t    head_addr,
  output lsb_pkg::word_t    head_wdata,
  output lsb_pkg::rob_id_t  head_dest
);
  import lsb_pkg::*;

  // entry payload
  lsb_op_e op    [`LSB_DEPTH];
  rob_id_t qj    [`LSB_DEPTH];
  rob_id_t qk    [`LSB_DEPTH];
  word_t   vj    [`LSB_DEPTH];
  word_t   vk    [`LSB_DEPTH];
  word_t   imm   [`LSB_DEPTH];
  rob_id_t dest  [`LSB_DEPTH];

  // entry control
  logic [`LSB_DEPTH-1:0] busy;
  logic [`LSB_DEPTH-1:0] committed;
  logic [`LSB_DEPTH-1:0] imm_pending;

  lsb_idx_t             head;
  lsb_idx_t             tail;
  logic [`LSB_IDX_W:0]  count;

  logic     alloc;
  logic     calc_found;
  lsb_idx_t calc_idx;
  logic     head_is_store;

  // tag matches either result source this cycle
  function automatic logic tag_hit(rob_id_t q);
    return (q != '0) &&
           ((cdb_valid && q == cdb_dest) || (result_valid && q == result_dest));
  endfunction

  function automatic word_t tag_value(rob_id_t q, word_t v);
    word_t r;
    r = v;
    if (q != '0 && result_valid && q == result_dest) begin
      r = result_value;
    end
    if (q != '0 && cdb_valid && q == cdb_dest) begin
      r = cdb_value;
    end
    return r;
  endfunction

  assign issue_ready = (count != `LSB_DEPTH);
  assign alloc = issue_valid && issue_ready;

  // lowest slot with a ready base gets its address
  always_comb begin
    calc_found = 1'b0;
    calc_idx = '0;
    for (int i = `LSB_DEPTH - 1; i >= 0; i--) begin
      if (busy[i] && qj[i] == '0 && imm_pending[i]) begin
        calc_found = 1'b1;
        calc_idx = lsb_idx_t'(i);
      end
    end
  end

  assign head_is_store = op[head] inside {SB, SH, SW};
  assign head_valid = busy[head] && qj[head] == '0 && qk[head] == '0 &&
                      !imm_pending[head] && (!head_is_store || committed[head]);
  assign head_op = op[head];
  assign head_addr = vj[head];
  assign head_wdata = vk[head];
  assign head_dest = dest[head];

  always_ff @(posedge clk) begin
    for (int i = 0; i < `LSB_DEPTH; i++) begin
      if (busy[i] && tag_hit(qj[i])) begin
        qj[i] <= '0;
        vj[i] <= tag_value(qj[i], vj[i]);
      end
      if (busy[i] && tag_hit(qk[i])) begin
        qk[i] <= '0;
        vk[i] <= tag_value(qk[i], vk[i]);
      end
    end

    // base plus immediate, base is already ready here
    if (calc_found) begin
      vj[calc_idx] <= vj[calc_idx] + imm[calc_idx];
    end

    if (alloc) begin
      op[tail] <= issue_op;
      dest[tail] <= issue_dest;
      imm[tail] <= issue_imm;
      qj[tail] <= tag_hit(issue_qj) ? '0 : issue_qj;
      vj[tail] <= tag_value(issue_qj, issue_vj);
      qk[tail] <= tag_hit(issue_qk) ? '0 : issue_qk;
      vk[tail] <= tag_value(issue_qk, issue_vk);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      busy <= '0;
      committed <= '0;
      imm_pending <= '0;
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (calc_found) begin
        imm_pending[calc_idx] <= 1'b0;
      end

      if (commit_valid) begin
        for (int i = 0; i < `LSB_DEPTH; i++) begin
          if (busy[i] && dest[i] == commit_dest) begin
            committed[i] <= 1'b1;
          end
        end
      end

      if (head_done) begin
        busy[head] <= 1'b0;
        head <= head + 1'b1;
      end

      if (alloc) begin
        busy[tail] <= 1'b1;
        committed[tail] <= 1'b0;
        imm_pending[tail] <= 1'b1;
        tail <= tail + 1'b1;
      end

      case ({alloc, head_done})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // count and busy bits must agree on the free slot
  a_alloc_free_slot: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus) alloc |-> !busy[tail]
  ) else $error("allocation into a busy slot");

  a_done_needs_head: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus) head_done |-> head_valid
  ) else $error("head_done without a ready head");

endmodule

/* source/data_cache.sv */
`timescale 1ns/1ps
`include "lsb_defines.svh"

module data_cache (
  input  logic              clk,
  input  logic              reset_from_rob_bus,
  input  logic              head_valid,
  input  lsb_pkg::lsb_op_e  head_op,
  input  lsb_pkg::addr_t    head_addr,
  input  lsb_pkg::word_t    head_wdata,
  input  logic              mem_ready,
  input  lsb_pkg::line_t    mem_rdata,
  output logic              head_done,
  output lsb_pkg::line_t    hit_line,
  output logic              mem_valid,
  output logic              mem_write,
  output lsb_pkg::addr_t    mem_addr,
  output lsb_pkg::line_t    mem_wdata
);
  import lsb_pkg::*;

  logic [`TAG_W-1:0]       tags  [`CACHE_LINES];
  line_t                   lines [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;
  logic [`CACHE_LINES-1:0] dirty;

  cache_state_e state;

  logic [`TAG_W-1:0]    req_tag;
  logic [`INDEX_W-1:0]  req_index;
  logic [`OFFSET_W-1:0] req_offset;
  logic [`OFFSET_W+2:0] lane;
  logic [`INDEX_W-1:0]  fill_index;
  logic                 hit;
  logic                 is_store;

  assign req_tag = head_addr[`XLEN-1 -: `TAG_W];
  assign req_index = head_addr[`OFFSET_W +: `INDEX_W];
  assign req_offset = head_addr[`OFFSET_W-1:0];
  assign lane = {req_offset, 3'b000};

  // outstanding request decides which line gets filled
  assign fill_index = mem_addr[`OFFSET_W +: `INDEX_W];

  assign hit = valid[req_index] && tags[req_index] == req_tag;
  assign is_store = head_op inside {SB, SH, SW};
  assign head_done = (state == IDLE) && head_valid && hit;
  assign hit_line = lines[req_index];

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= IDLE;
      valid <= '0;
      dirty <= '0;
      mem_valid <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (head_done && is_store) begin
            case (head_op)
              SB: lines[req_index][lane +: 8] <= head_wdata[7:0];
              SH: lines[req_index][lane +: 16] <= head_wdata[15:0];
              default: lines[req_index][lane +: `XLEN] <= head_wdata;
            endcase
            dirty[req_index] <= 1'b1;
          end else if (head_valid && !hit) begin
            // miss, fetch the new line first
            state <= REFILL;
            mem_valid <= 1'b1;
            mem_write <= 1'b0;
            mem_addr <= {req_tag, req_index, {`OFFSET_W{1'b0}}};
          end
        end

        REFILL: begin
          if (mem_ready) begin
            lines[fill_index] <= mem_rdata;
            tags[fill_index] <= mem_addr[`XLEN-1 -: `TAG_W];
            valid[fill_index] <= 1'b1;
            if (dirty[fill_index]) begin
              // old line still readable this edge
              state <= WRITEBACK;
              dirty[fill_index] <= 1'b0;
              mem_write <= 1'b1;
              mem_addr <= {tags[fill_index], fill_index, {`OFFSET_W{1'b0}}};
              mem_wdata <= lines[fill_index];
            end else begin
              state <= IDLE;
              mem_valid <= 1'b0;
            end
          end
        end

        WRITEBACK: begin
          if (mem_ready) begin
            state <= IDLE;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
          end
        end

        default: begin
          state <= IDLE;
          mem_valid <= 1'b0;
        end
      endcase
    end
  end

  // request held until the controller takes it
  a_mem_hold: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata)
  ) else $error("memory request changed before mem_ready");

endmodule

/* source/load_align.sv */
`timescale 1ns/1ps
`include "lsb_defines.svh"

module load_align (
  input  logic              clk,
  input  logic              reset_from_rob_bus,
  input  logic              head_done,
  input  lsb_pkg::lsb_op_e  head_op,
  input  lsb_pkg::addr_t    head_addr,
  input  lsb_pkg::rob_id_t  head_dest,
  input  lsb_pkg::line_t    hit_line,
  output logic              result_valid,
  output lsb_pkg::rob_id_t  result_dest,
  output lsb_pkg::word_t    result_value
);
  import lsb_pkg::*;

  line_t shifted;
  word_t extended;
  logic  is_load;

  // addressed byte moved down to bit 0
  assign shifted = hit_line >> {head_addr[`OFFSET_W-1:0], 3'b000};
  assign is_load = !(head_op inside {SB, SH, SW});

  always_comb begin
    case (head_op)
      LB:      extended = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      LH:      extended = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      LBU:     extended = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      LHU:     extended = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      default: extended = shifted[`XLEN-1:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= head_done && is_load;
    end
  end

  always_ff @(posedge clk) begin
    if (head_done && is_load) begin
      result_dest <= head_dest;
      result_value <= extended;
    end
  end

endmodule

/* source/ls_buffer.sv */
`timescale 1ns/1ps

module ls_buffer (
  input  logic              clk,
  input  logic              reset_from_rob_bus,
  input  logic              issue_valid,
  input  lsb_pkg::lsb_op_e  issue_op,
  input  lsb_pkg::rob_id_t  issue_dest,
  input  lsb_pkg::rob_id_t  issue_qj,
  input  lsb_pkg::rob_id_t  issue_qk,
  input  lsb_pkg::word_t    issue_vj,
  input  lsb_pkg::word_t    issue_vk,
  input  lsb_pkg::word_t    issue_imm,
  output logic              issue_ready,
  input  logic              cdb_valid,
  input  lsb_pkg::rob_id_t  cdb_dest,
  input  lsb_pkg::word_t    cdb_value,
  input  logic              commit_valid,
  input  lsb_pkg::rob_id_t  commit_dest,
  output logic              result_valid,
  output lsb_pkg::rob_id_t  result_dest,
  output lsb_pkg::word_t    result_value,
  output logic              mem_valid,
  output logic              mem_write,
  output lsb_pkg::addr_t    mem_addr,
  output lsb_pkg::line_t    mem_wdata,
  input  logic              mem_ready,
  input  lsb_pkg::line_t    mem_rdata
);
  import lsb_pkg::*;

  // head request between queue, cache and aligner
  logic    head_valid;
  lsb_op_e head_op;
  addr_t   head_addr;
  word_t   head_wdata;
  rob_id_t head_dest;
  logic    head_done;
  line_t   hit_line;

  ls_queue u_queue (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .issue_valid        (issue_valid),
    .issue_op           (issue_op),
    .issue_dest         (issue_dest),
    .issue_qj           (issue_qj),
    .issue_qk           (issue_qk),
    .issue_vj           (issue_vj),
    .issue_vk           (issue_vk),
    .issue_imm          (issue_imm),
    .cdb_valid          (cdb_valid),
    .cdb_dest           (cdb_dest),
    .cdb_value          (cdb_value),
    .result_valid       (result_valid),
    .result_dest        (result_dest),
    .result_value       (result_value),
    .commit_valid       (commit_valid),
    .commit_dest        (commit_dest),
    .head_done          (head_done),
    .issue_ready        (issue_ready),
    .head_valid         (head_valid),
    .head_op            (head_op),
    .head_addr          (head_addr),
    .head_wdata         (head_wdata),
    .head_dest          (head_dest)
  );

  data_cache u_cache (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .head_valid         (head_valid),
    .head_op            (head_op),
    .head_addr          (head_addr),
    .head_wdata         (head_wdata),
    .mem_ready          (mem_ready),
    .mem_rdata          (mem_rdata),
    .head_done          (head_done),
    .hit_line           (hit_line),
    .mem_valid          (mem_valid),
    .mem_write          (mem_write),
    .mem_addr           (mem_addr),
    .mem_wdata          (mem_wdata)
  );

  // load result also feeds back into the queue wakeup
  load_align u_align (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .head_done          (head_done),
    .head_op            (head_op),
    .head_addr          (head_addr),
    .head_dest          (head_dest),
    .hit_line           (hit_line),
    .result_valid       (result_valid),
    .result_dest        (result_dest),
    .result_value       (result_value)
  );

endmodule

/* tb/mem_ctrl_model.sv */
`timescale 1ns/1ps

module mem_ctrl_model (
  input  logic            clk,
  input  logic            reset_from_rob_bus,
  input  logic            mem_valid,
  input  logic            mem_write,
  input  lsb_pkg::addr_t  mem_addr,
  input  lsb_pkg::line_t  mem_wdata,
  output logic            mem_ready,
  output lsb_pkg::line_t  mem_rdata,
  output int unsigned     write_count
);
  import lsb_pkg::*;

  // bytes that were written, all others follow the fixed pattern
  logic [7:0]  mem_bytes [logic [31:0]];
  logic [31:0] rng;
  int unsigned delay;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic line_t read_line(addr_t a);
    line_t l;
    addr_t b;
    for (int i = 0; i < 16; i++) begin
      b = a + i;
      l[8*i +: 8] = mem_bytes.exists(b) ? mem_bytes[b] :
                    (b[7:0] ^ b[15:8] ^ b[23:16] ^ b[31:24] ^ 8'h5a);
    end
    return l;
  endfunction

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    write_count = 0;
    delay = 0;
    rng = 32'he8d4;
  end

  // write log, taken at the handshake edge
  always @(posedge clk) begin
    if (!reset_from_rob_bus && mem_valid && mem_ready && mem_write) begin
      for (int i = 0; i < 16; i++) begin
        mem_bytes[mem_addr + i] = mem_wdata[8*i +: 8];
      end
      write_count++;
    end
  end

  always @(negedge clk) begin
    if (reset_from_rob_bus) begin
      mem_ready = 1'b0;
      delay = 0;
    end else if (mem_ready) begin
      mem_ready = 1'b0;
      rng = xorshift32(rng);
      delay = rng % 6;
    end else if (mem_valid) begin
      if (delay == 0) begin
        mem_ready = 1'b1;
        if (!mem_write) begin
          mem_rdata = read_line(mem_addr);
        end
      end else begin
        delay--;
      end
    end
  end

endmodule

/* tb/tb_ls_buffer.sv */
`timescale 1ns/1ps

module tb_ls_buffer;
  import lsb_pkg::*;

  localparam int RANDOM_OPS = 60;
  // about 30 cycles per operation at worst, plus the directed parts
  localparam int CYCLE_LIMIT = 4000;

  logic clk;
  logic reset_from_rob_bus;
  logic issue_valid, issue_ready, cdb_valid, commit_valid;
  lsb_op_e issue_op;
  rob_id_t issue_dest, issue_qj, issue_qk, cdb_dest, commit_dest, result_dest;
  word_t issue_vj, issue_vk, issue_imm, cdb_value, result_value;
  logic result_valid, mem_valid, mem_write, mem_ready;
  addr_t mem_addr, wb_addr;
  line_t mem_wdata, mem_rdata, wb_expect;
  int unsigned write_count;

  int errors, loads_checked, cycles;
  logic [31:0] rng;
  logic [7:0] shadow [logic [31:0]];
  addr_t exp_addr [$];
  lsb_op_e exp_op [$];
  rob_id_t exp_tag [$];
  logic exp_avail, store_hold, base_pending, wb_avail;
  word_t exp_value;
  rob_id_t exp_dest, next_tag;

  // resident line per cache index, in program order
  addr_t exp_wb [$];
  addr_t line_addr [16];
  logic [15:0] line_valid, line_dirty;

  ls_buffer u_dut (.*);

  mem_ctrl_model u_mem (.*);

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] mem_byte(addr_t a);
    return shadow.exists(a) ? shadow[a] : (a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a);
  endfunction

  function automatic word_t load_value(addr_t a, lsb_op_e op);
    word_t w;
    w = {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
    case (op)
      LB:      return {{24{w[7]}}, w[7:0]};
      LH:      return {{16{w[15]}}, w[15:0]};
      LBU:     return {24'h0, w[7:0]};
      LHU:     return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic line_t shadow_line(addr_t a);
    line_t l;
    for (int i = 0; i < 16; i++) begin
      l[8*i +: 8] = mem_byte({a[31:4], 4'h0} + i);
    end
    return l;
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  // expected front of the load FIFO, read from the shadow every cycle
  always @(posedge clk) begin
    if (!reset_from_rob_bus && result_valid && exp_addr.size() != 0) begin
      void'(exp_addr.pop_front());
      void'(exp_op.pop_front());
      void'(exp_tag.pop_front());
      loads_checked++;
    end
    exp_avail <= exp_addr.size() != 0;
    if (exp_addr.size() != 0) begin
      exp_value <= load_value(exp_addr[0], exp_op[0]);
      exp_dest <= exp_tag[0];
    end
    // next dirty victim expected on the memory bus
    if (!reset_from_rob_bus && mem_valid && mem_ready && mem_write &&
        exp_wb.size() != 0) begin
      void'(exp_wb.pop_front());
    end
    wb_avail <= exp_wb.size() != 0;
    if (exp_wb.size() != 0) begin
      wb_addr <= exp_wb[0];
      wb_expect <= shadow_line(exp_wb[0]);
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    $fell(reset_from_rob_bus) |-> issue_ready && !result_valid && !mem_valid)
    else report_mismatch("outputs not idle after reset");

  a_load_data: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    result_valid |-> exp_avail && result_value == exp_value && result_dest == exp_dest)
    else report_mismatch("load result differs from the expected load");

  a_store_first: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    result_valid |-> !store_hold)
    else report_mismatch("load result before the older store was committed");

  a_wakeup: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    result_valid |-> !base_pending)
    else report_mismatch("load result before its base tag was broadcast");

  a_writeback: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    mem_valid && mem_ready && mem_write |-> wb_avail && mem_addr == wb_addr &&
      mem_wdata == wb_expect)
    else report_mismatch("write-back request differs from the evicted dirty line");

  a_request_hold: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_addr) && $stable(mem_write) && $stable(mem_wdata))
    else report_mismatch("memory request changed before mem_ready");

  // direct-mapped write-back, queues the victim of every dirty eviction
  task automatic track_cache(input addr_t eff, input logic store);
    addr_t line;
    logic [3:0] idx;
    line = {eff[31:4], 4'h0};
    idx = eff[7:4];
    if (!line_valid[idx] || line_addr[idx] != line) begin
      if (line_valid[idx] && line_dirty[idx]) begin
        exp_wb.push_back(line_addr[idx]);
      end
      line_valid[idx] = 1'b1;
      line_dirty[idx] = 1'b0;
      line_addr[idx] = line;
    end
    if (store) begin
      line_dirty[idx] = 1'b1;
    end
  endtask

  task automatic issue_entry(input lsb_op_e op, input rob_id_t qj, input word_t vj,
                             input word_t vk, input word_t imm, input addr_t eff,
                             output rob_id_t tag);
    tag = next_tag;
    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    issue_valid = 1'b1;
    issue_op = op;
    issue_dest = tag;
    issue_qj = qj;
    issue_qk = '0;
    issue_vj = vj;
    issue_vk = vk;
    issue_imm = imm;
    if (!(op inside {SB, SH, SW})) begin
      exp_addr.push_back(eff);
      exp_op.push_back(op);
      exp_tag.push_back(tag);
    end
    track_cache(eff, op inside {SB, SH, SW});
    while (!issue_ready) @(negedge clk);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  function automatic addr_t pick_addr(lsb_op_e op, logic [31:0] r);
    addr_t a;
    a = 32'h1000 + (r & 32'h3ff);
    if (op inside {LH, LHU, SH}) a[0] = 1'b0;
    if (op inside {LW, SW}) a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic random_load(input addr_t fixed, input logic use_fixed);
    lsb_op_e op;
    addr_t a;
    word_t imm;
    rob_id_t tag;
    rng = xorshift32(rng);
    op = lsb_op_e'(rng % 5);
    a = use_fixed ? fixed : pick_addr(op, rng >> 8);
    if (use_fixed) op = LW;
    imm = {{28{rng[27]}}, rng[27:24]};
    issue_entry(op, '0, a - imm, '0, imm, a, tag);
  endtask

  task automatic drain_loads();
    while (exp_addr.size() != 0) @(negedge clk);
  endtask

  task automatic commit_store(input rob_id_t tag, input addr_t a, input lsb_op_e op,
                              input word_t data);
    @(negedge clk);
    commit_valid = 1'b1;
    commit_dest = tag;
    store_hold = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (i == 0 || (i == 1 && op != SB) || op == SW) shadow[a + i] = data[8*i +: 8];
    end
    @(negedge clk);
    commit_valid = 1'b0;
  endtask

  // store, held a few cycles before commit, then a load of the same word
  task automatic store_then_load();
    lsb_op_e op;
    addr_t a;
    word_t data;
    rob_id_t tag;
    drain_loads();
    rng = xorshift32(rng);
    op = lsb_op_e'(5 + rng % 3);
    a = pick_addr(op, rng >> 4);
    data = xorshift32(rng ^ 32'h9e37);
    store_hold = 1'b1;
    issue_entry(op, '0, a - 32'd8, data, 32'd8, a, tag);
    repeat (3 + rng[30:29]) @(negedge clk);
    commit_store(tag, a, op, data);
    random_load({a[31:2], 2'b00}, 1'b1);
  endtask

  initial begin
    rob_id_t tag;
    addr_t a;
    reset_from_rob_bus = 1'b1;
    {issue_valid, cdb_valid, commit_valid} = '0;
    issue_op = LW;
    {issue_dest, issue_qj, issue_qk, cdb_dest, commit_dest} = '0;
    {issue_vj, issue_vk, issue_imm, cdb_value} = '0;
    {errors, loads_checked, cycles} = '0;
    {store_hold, base_pending, exp_avail, wb_avail} = '0;
    line_valid = '0;
    line_dirty = '0;
    next_tag = 4'd1;
    rng = 32'he8d4;
    repeat (3) @(negedge clk);
    reset_from_rob_bus = 1'b0;

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rng = xorshift32(rng);
      if (rng % 3 == 0) store_then_load();
      else random_load('0, 1'b0);
    end

    // base arrives later on the result bus
    drain_loads();
    base_pending = 1'b1;
    tag = next_tag;
    issue_entry(LW, (tag % 4'd15) + 4'd1, 32'hdead0000, '0, 32'd4, 32'h1204, tag);
    repeat (6) @(negedge clk);
    cdb_valid = 1'b1;
    cdb_dest = (tag % 4'd15) + 4'd1;
    cdb_value = 32'h1200;
    base_pending = 1'b0;
    @(negedge clk);
    cdb_valid = 1'b0;

    // full queue behind an uncommitted store
    drain_loads();
    a = 32'h1340;
    store_hold = 1'b1;
    issue_entry(SW, '0, a, 32'h8badf00d, '0, a, tag);
    fork
      begin
        random_load(a, 1'b1);
        repeat (15) random_load('0, 1'b0);
      end
      begin
        while (issue_ready) @(negedge clk);
        commit_store(tag, a, SW, 32'h8badf00d);
      end
    join
    drain_loads();
    while (mem_valid) @(negedge clk);
    repeat (4) @(negedge clk);

    if (write_count == 0) begin
      errors++;
      $display("no dirty line was ever written back to memory");
    end
    if (exp_wb.size() != 0) begin
      errors++;
      $display("%0d evicted dirty lines were never written back", exp_wb.size());
    end
    $display("checks done: %0d errors, %0d loads checked, %0d memory writes",
             errors, loads_checked, write_count);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+source
source/lsb_pkg.sv
source/ls_queue.sv
source/data_cache.sv
source/load_align.sv
source/ls_buffer.sv
tb/mem_ctrl_model.sv
tb/tb_ls_buffer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ls_buffer -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench failed" sim.log; then
  exit 1
fi
grep -q "Testbench passed" sim.log
